// File: all.f
+incdir+.
pred_pkg.sv
btb_pkg.sv
assoc_comparator.sv
lru_tracker.sv
btb_table.sv
branch_target_buffer.sv
tb_btb.sv

// File: tb_btb_cases.svh
// Directed rows first, then rows the LRU model predicts
task automatic load_cases();
    // --------------------------------------------------
    // Cold table
    // --------------------------------------------------
    add_case("reset_miss_a",    1'b1, fetch_req(1'b0, 'h100, 'h104), no_resolve, 1'b0, wt, 'h104);
    add_case("reset_miss_b",    1'b1, fetch_req(1'b0, 'h200, 'h204), no_resolve, 1'b0, wt, 'h204);

    add_case("if_alloc",        1'b1, fetch_req(1'b1, 'h100, 'h180), no_resolve, 1'b0, wt, 'h180);
    add_case("if_hit",          1'b1, fetch_req(1'b0, 'h100, 'h104), no_resolve, 1'b1, wt, 'h180);

    // --------------------------------------------------
    // Counter walk on line 0, IF watches the old state
    // --------------------------------------------------
    add_case("id_strong_t",     1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b0, 'h100, 'h1a0), 1'b1, wt, 'h180);
    add_case("id_saturate_t",   1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b0, 'h100, 'h1a0), 1'b1, st, 'h1a0);
    add_case("id_mis_st",       1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b1, 'h100, 'h1c0), 1'b1, st, 'h1a0);
    add_case("id_mis_wt",       1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b1, 'h100, 'h1c0), 1'b1, wt, 'h1c0);
    add_case("id_strong_nt",    1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b0, 'h100, 'h1c0), 1'b1, wnt, 'h1c0);
    add_case("id_saturate_nt",  1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b0, 'h100, 'h1c0), 1'b1, snt, 'h1c0);
    add_case("id_mis_snt",      1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b1, 'h100, 'h1e0), 1'b1, snt, 'h1c0);
    add_case("id_mis_wnt",      1'b1, fetch_req(1'b0, 'h100, 'h104),
             resolve_req(1'b1, 1'b1, 'h100, 'h1e0), 1'b1, wnt, 'h1e0);
    add_case("walk_done",       1'b1, fetch_req(1'b0, 'h100, 'h104), no_resolve, 1'b1, wt, 'h1e0);

    // Both stages miss, line 1 goes to ID
    add_case("dual_miss",       1'b1, fetch_req(1'b1, 'h300, 'h380),
             resolve_req(1'b1, 1'b0, 'h400, 'h480), 1'b0, wt, 'h380);
    add_case("dual_id_kept",    1'b1, fetch_req(1'b0, 'h400, 'h404), no_resolve, 1'b1, wt, 'h480);
    add_case("dual_if_dropped", 1'b1, fetch_req(1'b0, 'h300, 'h304), no_resolve, 1'b0, wt, 'h304);

    // Frozen table
    add_case("frozen_alloc",    1'b0, fetch_req(1'b1, 'h500, 'h580),
             resolve_req(1'b1, 1'b1, 'h100, 'h990), 1'b0, wt, 'h580);
    add_case("frozen_hit",      1'b0, fetch_req(1'b0, 'h100, 'h104), no_resolve, 1'b1, wt, 'h1e0);
    add_case("frozen_miss",     1'b1, fetch_req(1'b0, 'h500, 'h504), no_resolve, 1'b0, wt, 'h504);

    // --------------------------------------------------
    // Fill lines 2..7, then evict
    // --------------------------------------------------
    add_case("fill_2",          1'b1, fetch_req(1'b1, 'h600, 'h680), no_resolve, 1'b0, wt, 'h680);
    add_case("fill_3",          1'b1, fetch_req(1'b1, 'h700, 'h780), no_resolve, 1'b0, wt, 'h780);
    add_case("fill_4",          1'b1, fetch_req(1'b1, 'h800, 'h880), no_resolve, 1'b0, wt, 'h880);
    add_case("fill_5",          1'b1, fetch_req(1'b1, 'h900, 'h980), no_resolve, 1'b0, wt, 'h980);
    add_case("fill_6",          1'b1, fetch_req(1'b1, 'ha00, 'ha80), no_resolve, 1'b0, wt, 'ha80);
    add_case("fill_7",          1'b1, fetch_req(1'b1, 'hb00, 'hb80), no_resolve, 1'b0, wt, 'hb80);
    add_case("touch_recent",    1'b1, fetch_req(1'b1, 'h100, 'h104), no_resolve, 1'b1, wt, 'h1e0);
    add_case("evict",           1'b1, fetch_req(1'b1, 'hc00, 'hc80), no_resolve, 1'b0, wt, 'hc80);
    add_case("evicted_miss",    1'b1, fetch_req(1'b0, 'h400, 'h404), no_resolve, 1'b0, wt, 'h404);
    add_case("recent_hit",      1'b1, fetch_req(1'b0, 'h100, 'h104), no_resolve, 1'b1, wt, 'h1e0);
    add_case("new_line_hit",    1'b1, fetch_req(1'b0, 'hc00, 'hc04), no_resolve, 1'b1, wt, 'hc80);

    add_random(40);
endtask

// File: tb_btb.sv
`timescale 1ns/1ns
`default_nettype none
`include "btb_cfg.svh"

module tb_btb;

    typedef logic [`BTB_ADDR_W-1:0] addr_t;

    typedef struct {
        string                 name;
        bit                    from_lfsr; // Filled in at run time
        logic                  en;
        btb_pkg::fetch_query_t fetch;
        btb_pkg::resolve_t     resolve;
        logic                  hit;
        pred_pkg::dir_t        taken;
        addr_t                 target;
    } case_t;

    localparam pred_pkg::dir_t    snt = pred_pkg::STRONG_NOT_TAKEN;
    localparam pred_pkg::dir_t    wnt = pred_pkg::WEAK_NOT_TAKEN;
    localparam pred_pkg::dir_t    wt  = pred_pkg::WEAK_TAKEN;
    localparam pred_pkg::dir_t    st  = pred_pkg::STRONG_TAKEN;
    localparam btb_pkg::resolve_t no_resolve = '0;

    logic                  clk;
    logic                  rst;
    logic                  en;
    btb_pkg::fetch_query_t fetch;
    btb_pkg::resolve_t     resolve;
    logic                  if_hit;
    pred_pkg::dir_t        taken;
    addr_t                 target;

    case_t       cases[$];
    logic [31:0] lfsr_state;
    int          checks_run;
    int          row_errors;
    int          rows_failed;
    int          watchdog_ns;

    // Reference model
    logic       m_valid [`BTB_LINES];
    addr_t      m_tag   [`BTB_LINES];
    addr_t      m_tgt   [`BTB_LINES];
    logic [1:0] m_ctr   [`BTB_LINES];
    int         m_age   [`BTB_LINES]; // 0 is most recent

    branch_target_buffer dut_i (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .fetch   (fetch),
        .resolve (resolve),
        .if_hit  (if_hit),
        .taken   (taken),
        .target  (target)
    );

    always #2 clk = ~clk;

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic btb_pkg::fetch_query_t fetch_req(input logic b, input addr_t pc,
                                                        input addr_t pred);
        btb_pkg::fetch_query_t q;
        q.branch    = b;
        q.pc        = pc;
        q.pred_addr = pred;
        return q;
    endfunction

    function automatic btb_pkg::resolve_t resolve_req(input logic b, input logic mis,
                                                      input addr_t pc, input addr_t tgt);
        btb_pkg::resolve_t r;
        r.branch     = b;
        r.mispredict = mis;
        r.pc         = pc;
        r.target     = tgt;
        return r;
    endfunction

    task automatic add_case(input string name, input logic row_en,
                            input btb_pkg::fetch_query_t f, input btb_pkg::resolve_t r,
                            input logic hit, input pred_pkg::dir_t dir, input addr_t tgt);
        case_t row;
        row.name      = name;
        row.from_lfsr = 1'b0;
        row.en        = row_en;
        row.fetch     = f;
        row.resolve   = r;
        row.hit       = hit;
        row.taken     = dir;
        row.target    = tgt;
        cases.push_back(row);
    endtask

    task automatic add_random(input int count);
        case_t row;
        row.from_lfsr = 1'b1;
        for (int i = 0; i < count; i++) begin
            cases.push_back(row);
        end
    endtask

    // Fibonacci LFSR on taps 32 22 2 1
    function automatic logic rand_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    // PCs drawn from a pool twice the line count
    task automatic fill_random(inout case_t row, input int idx);
        row.name               = $sformatf("random_%0d", idx);
        row.en                 = (rand_word(3) != 0);
        row.fetch.branch       = rand_bit();
        row.fetch.pc           = 32'h2000 + (rand_word(4) << 2);
        row.fetch.pred_addr    = rand_word(32);
        row.resolve.branch     = rand_bit();
        row.resolve.mispredict = rand_bit();
        row.resolve.pc         = 32'h2000 + (rand_word(4) << 2);
        row.resolve.target     = rand_word(32);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    task automatic model_reset();
        for (int i = 0; i < `BTB_LINES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_tgt[i]   = '0;
            m_ctr[i]   = wt;
            m_age[i]   = i;
        end
    endtask

    function automatic int find_line(input addr_t pc);
        int ln;
        ln = -1;
        for (int i = `BTB_LINES - 1; i >= 0; i--) begin
            if (m_valid[i] && m_tag[i] == pc) ln = i;
        end
        return ln;
    endfunction

    function automatic logic [1:0] next_ctr(input logic [1:0] c, input logic mis);
        if (mis) begin
            return c[1] ? c - 2'd1 : c + 2'd1; // One step toward the other side
        end else begin
            return c[1] ? 2'd3 : 2'd0;
        end
    endfunction

    task automatic touch_age(input int ln);
        int old;
        old = m_age[ln];
        for (int i = 0; i < `BTB_LINES; i++) begin
            if (i == ln) m_age[i] = 0;
            else if (m_age[i] < old) m_age[i]++;
        end
    endtask

    task automatic write_line(input int ln, input addr_t pc, input addr_t tgt);
        m_valid[ln] = 1'b1;
        m_tag[ln]   = pc;
        m_tgt[ln]   = tgt;
        m_ctr[ln]   = wt;
    endtask

    task automatic predict(inout case_t row);
        int ln;
        ln      = find_line(row.fetch.pc);
        row.hit = (ln >= 0);
        if (ln >= 0) begin
            row.taken  = pred_pkg::dir_t'(m_ctr[ln]);
            row.target = m_tgt[ln];
        end else begin
            row.taken  = wt;
            row.target = row.fetch.pred_addr;
        end
    endtask

    // State after the clock edge that takes this row
    task automatic model_clock(input case_t row);
        int         if_ln;
        int         id_ln;
        int         oldest;
        int         alloc;
        int         if_slot;
        int         id_slot;
        logic       if_alloc;
        logic       id_alloc;
        logic [1:0] stepped;
        if (row.en) begin
            if_ln  = find_line(row.fetch.pc);
            id_ln  = find_line(row.resolve.pc);
            oldest = 0;
            for (int i = 1; i < `BTB_LINES; i++) begin
                if (m_age[i] > m_age[oldest]) oldest = i;
            end
            alloc = oldest;
            for (int i = `BTB_LINES - 1; i >= 0; i--) begin
                if (!m_valid[i]) alloc = i; // Free line first
            end
            id_slot  = (id_ln >= 0) ? id_ln : alloc;
            if_slot  = (if_ln >= 0) ? if_ln : alloc;
            id_alloc = row.resolve.branch && (id_ln < 0);
            // IF yields when ID claims the same line
            if_alloc = row.fetch.branch && (if_ln < 0)
                       && !(row.resolve.branch && (id_slot == alloc));
            stepped  = next_ctr(m_ctr[id_slot], row.resolve.mispredict);
            if (if_alloc) write_line(alloc, row.fetch.pc, row.fetch.pred_addr);
            if (id_alloc) begin
                write_line(alloc, row.resolve.pc, row.resolve.target);
            end else if (row.resolve.branch) begin
                m_tgt[id_slot] = row.resolve.target;
                m_ctr[id_slot] = stepped;
            end
            if (row.fetch.branch && (if_ln >= 0 || if_alloc)) touch_age(if_slot);
            if (row.resolve.branch) touch_age(id_slot);
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks_run++;
        assert (act === exp)
        else begin
            $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            row_errors++;
        end
    endtask

    `include "tb_btb_cases.svh"

    initial begin
        case_t row;
        clk         = 1'b0;
        rst         = 1'b1;
        en          = 1'b0;
        fetch       = '0;
        resolve     = '0;
        lfsr_state  = 32'h43b1;
        checks_run  = 0;
        rows_failed = 0;
        load_cases();
        model_reset();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int k = 0; k < cases.size(); k++) begin
            @(negedge clk);
            row = cases[k];
            if (row.from_lfsr) begin
                fill_random(row, k);
                predict(row);
            end
            en      = row.en;
            fetch   = row.fetch;
            resolve = row.resolve;
            #1; // Outputs settled before the rising edge
            row_errors = 0;
            check_value(row.name, "if_hit", 32'(row.hit), 32'(if_hit));
            check_value(row.name, "taken", 32'(row.taken), 32'(taken));
            check_value(row.name, "target", row.target, target);
            if (row_errors == 0) begin
                $display("pass  %s", row.name);
            end else begin
                $display("fail  %s", row.name);
                rows_failed++;
            end
            model_clock(row);
        end

        $display("rows run %0d, passed %0d, failed %0d",
                 cases.size(), cases.size() - rows_failed, rows_failed);
        if (checks_run == 0) $display("No check was evaluated during the run");
        if (rows_failed == 0 && checks_run > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Rows plus reset plus margin at 4 ns each
    initial begin
        #1;
        watchdog_ns = (cases.size() + 16 + 20) * 4;
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns with the case loop still running", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: branch_target_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "btb_cfg.svh"

module branch_target_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          en,
    input  wire btb_pkg::fetch_query_t   fetch,
    input  wire btb_pkg::resolve_t       resolve,
    output logic                         if_hit,
    output pred_pkg::dir_t               taken,
    output logic [`BTB_ADDR_W-1:0]       target
);

    btb_pkg::tag_array_t   tags;
    btb_pkg::lookup_t      if_look;
    btb_pkg::lookup_t      id_look;
    logic                  if_touch;
    logic                  id_touch;
    logic [`BTB_IDX_W-1:0] if_line;
    logic [`BTB_IDX_W-1:0] id_line;
    logic [`BTB_IDX_W-1:0] victim;

    // Two searches of the same table
    assoc_comparator if_comparator_i (
        .pc   (fetch.pc),
        .tags (tags),
        .look (if_look)
    );

    assoc_comparator id_comparator_i (
        .pc   (resolve.pc),
        .tags (tags),
        .look (id_look)
    );

    btb_table table_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .fetch    (fetch),
        .resolve  (resolve),
        .if_look  (if_look),
        .id_look  (id_look),
        .victim   (victim),
        .tags     (tags),
        .if_touch (if_touch),
        .id_touch (id_touch),
        .if_line  (if_line),
        .id_line  (id_line),
        .if_hit   (if_hit),
        .taken    (taken),
        .target   (target)
    );

    lru_tracker lru_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .if_touch (if_touch),
        .id_touch (id_touch),
        .if_line  (if_line),
        .id_line  (id_line),
        .victim   (victim)
    );

endmodule

`default_nettype wire

// File: btb_table.sv
`timescale 1ns/1ns
`default_nettype none
`include "btb_cfg.svh"

module btb_table (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          en,
    input  wire btb_pkg::fetch_query_t   fetch,
    input  wire btb_pkg::resolve_t       resolve,
    input  wire btb_pkg::lookup_t        if_look,
    input  wire btb_pkg::lookup_t        id_look,
    input  wire [`BTB_IDX_W-1:0]         victim,
    output btb_pkg::tag_array_t          tags,
    output logic                         if_touch,
    output logic                         id_touch,
    output logic [`BTB_IDX_W-1:0]        if_line,
    output logic [`BTB_IDX_W-1:0]        id_line,
    output logic                         if_hit,
    output pred_pkg::dir_t               taken,
    output logic [`BTB_ADDR_W-1:0]       target
);

    typedef logic [`BTB_IDX_W-1:0] idx_t;

    btb_pkg::entry_t lines [`BTB_LINES];

    idx_t alloc_line;   // Where a miss lands
    logic id_alloc;
    logic if_alloc;

    // --------------------------------------------------
    // Line selection
    // --------------------------------------------------

    // Free lines first, LRU victim once full
    always_comb begin
        alloc_line = victim;
        for (int i = `BTB_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                alloc_line = idx_t'(i);
            end
        end
    end

    assign id_line  = id_look.hit ? id_look.line : alloc_line;
    assign if_line  = if_look.hit ? if_look.line : alloc_line;
    assign id_alloc = resolve.branch && !id_look.hit;

    // ID wins any clash over the same line
    assign if_alloc = fetch.branch && !if_look.hit
                      && !(resolve.branch && (id_line == alloc_line));

    assign if_touch = fetch.branch && (if_look.hit || if_alloc);
    assign id_touch = resolve.branch;

    // --------------------------------------------------
    // Table writes
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BTB_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (en) begin
            if (if_alloc) begin
                lines[alloc_line] <= '{
                    valid:  1'b1,
                    tag:    fetch.pc,
                    target: fetch.pred_addr,
                    ctr:    pred_pkg::DIR_RESET
                };
            end
            if (id_alloc) begin
                lines[alloc_line] <= '{
                    valid:  1'b1,
                    tag:    resolve.pc,
                    target: resolve.target,
                    ctr:    pred_pkg::DIR_RESET
                };
            end else if (resolve.branch) begin
                lines[id_line].target <= resolve.target;
                lines[id_line].ctr    <= pred_pkg::dir_step(lines[id_line].ctr,
                                                            resolve.mispredict);
            end
        end
    end

    // Search view for both comparators
    always_comb begin
        for (int i = 0; i < `BTB_LINES; i++) begin
            tags[i].valid = lines[i].valid;
            tags[i].tag   = lines[i].tag;
        end
    end

    // IF prediction
    assign if_hit = if_look.hit;
    assign taken  = if_look.hit ? lines[if_look.line].ctr : pred_pkg::DIR_RESET;
    assign target = if_look.hit ? lines[if_look.line].target : fetch.pred_addr; // Pass-through

endmodule

`default_nettype wire

// File: lru_tracker.sv
`timescale 1ns/1ns
`default_nettype none
`include "btb_cfg.svh"

module lru_tracker (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  en,
    input  wire                  if_touch,
    input  wire                  id_touch,
    input  wire [`BTB_IDX_W-1:0] if_line,
    input  wire [`BTB_IDX_W-1:0] id_line,
    output logic [`BTB_IDX_W-1:0] victim
);

    typedef logic [`BTB_IDX_W-1:0] idx_t;
    typedef idx_t [`BTB_LINES-1:0] age_vec_t;

    age_vec_t ages;      // 0 is most recent
    age_vec_t ages_if;
    age_vec_t ages_next;

    // One touch on a full age vector
    function automatic age_vec_t touch(input age_vec_t cur, input idx_t line);
        age_vec_t res;
        idx_t     old_age;
        res     = cur;
        old_age = cur[line];
        for (int i = 0; i < `BTB_LINES; i++) begin
            if (idx_t'(i) == line) begin
                res[i] = '0;
            end else if (cur[i] < old_age) begin
                res[i] = cur[i] + 1'b1;
            end
        end
        return res;
    endfunction

    // --------------------------------------------------
    // IF touch first, then ID on top of it
    // --------------------------------------------------
    always_comb begin
        ages_if   = if_touch ? touch(ages, if_line) : ages;
        ages_next = id_touch ? touch(ages_if, id_line) : ages_if;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BTB_LINES; i++) begin
                ages[i] <= idx_t'(i); // Line 7 starts oldest
            end
        end else if (en) begin
            ages <= ages_next;
        end
    end

    // --------------------------------------------------
    // Oldest line
    // --------------------------------------------------
    always_comb begin
        idx_t oldest;
        oldest = '0;
        for (int i = 1; i < `BTB_LINES; i++) begin
            if (ages[i] > ages[oldest]) begin
                oldest = idx_t'(i);
            end
        end
        victim = oldest;
    end

endmodule

`default_nettype wire

// File: assoc_comparator.sv
`timescale 1ns/1ns
`default_nettype none
`include "btb_cfg.svh"

module assoc_comparator (
    input  wire [`BTB_ADDR_W-1:0] pc,
    input  wire btb_pkg::tag_array_t tags,
    output btb_pkg::lookup_t look
);

    typedef logic [`BTB_IDX_W-1:0] idx_t;

    logic [`BTB_LINES-1:0] match;

    // All lines compared at once
    always_comb begin
        for (int i = 0; i < `BTB_LINES; i++) begin
            match[i] = tags[i].valid && (tags[i].tag == pc);
        end
    end

    // Priority encode, lowest line wins
    always_comb begin
        look.hit  = |match;
        look.line = '0;
        for (int i = `BTB_LINES - 1; i >= 0; i--) begin
            if (match[i]) begin
                look.line = idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: btb_pkg.sv
`default_nettype none
`include "btb_cfg.svh"

package btb_pkg;

    // Result of one associative search
    typedef struct packed {
        logic                  hit;
        logic [`BTB_IDX_W-1:0] line;
    } lookup_t;

    // From the fetch stage
    typedef struct packed {
        logic                   branch;
        logic [`BTB_ADDR_W-1:0] pc;
        logic [`BTB_ADDR_W-1:0] pred_addr; // Fallback when the BTB misses
    } fetch_query_t;

    // From the decode stage
    typedef struct packed {
        logic                   branch;
        logic                   mispredict;
        logic [`BTB_ADDR_W-1:0] pc;
        logic [`BTB_ADDR_W-1:0] target;
    } resolve_t;

    typedef struct packed {
        logic                   valid;
        logic [`BTB_ADDR_W-1:0] tag; // Full PC
        logic [`BTB_ADDR_W-1:0] target;
        pred_pkg::dir_t         ctr;
    } entry_t;

    // What the comparators see of each line
    typedef struct packed {
        logic                   valid;
        logic [`BTB_ADDR_W-1:0] tag;
    } tag_slot_t;

    typedef tag_slot_t [`BTB_LINES-1:0] tag_array_t;

endpackage

`default_nettype wire

// File: pred_pkg.sv
`default_nettype none

package pred_pkg;

    // Two-bit saturating direction counter
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } dir_t;

    localparam dir_t DIR_RESET = WEAK_TAKEN; // New lines and misses

    // Correct guess strengthens, a miss steps across the middle
    function automatic dir_t dir_step(input dir_t cur, input logic mispredict);
        dir_t nxt;
        case (cur)
            STRONG_TAKEN:   nxt = mispredict ? WEAK_TAKEN     : STRONG_TAKEN;
            WEAK_TAKEN:     nxt = mispredict ? WEAK_NOT_TAKEN : STRONG_TAKEN;
            WEAK_NOT_TAKEN: nxt = mispredict ? WEAK_TAKEN     : STRONG_NOT_TAKEN;
            default:        nxt = mispredict ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
        endcase
        return nxt;
    endfunction

endpackage

`default_nettype wire

// File: btb_cfg.svh
`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// PC and target width
`define BTB_ADDR_W 32

// Fully associative, one set
`define BTB_LINES  8
`define BTB_IDX_W  3

`endif
